// ==== verilog/ipv4_csum_pkg.sv ====
// Shared constants and types for the IPv4 header checksum block
// Header length is fixed at 20 bytes, so options (IHL > 5) are not supported

package ipv4_csum_pkg;

  // One header word as it arrives on the stream
  localparam int WORD_W = 16;

  // Words in a 20-byte header without options
  localparam int HDR_WORDS = 10;

  // Position of the checksum field inside the header
  localparam int CSUM_IDX = 5;

  // Width of the word index, enough for 0 to HDR_WORDS-1
  localparam int IDX_W = 4;

  // Registered stages from start to result
  localparam int TREE_LAT = 5;

  // Nine words that are summed, and the received checksum field kept aside
  typedef struct packed {
    logic [HDR_WORDS-2:0][WORD_W-1:0] sum_words;
    logic [WORD_W-1:0]                rx_csum;
  } hdr_words_t;

  // Computed checksum and whether the received field agreed with it
  typedef struct packed {
    logic [WORD_W-1:0] csum;
    logic              match;
  } csum_result_t;

endpackage

// ==== verilog/hdr_word_counter.sv ====
// Word index counter, wraps to zero after the last header word
// A clear shows index zero at once so that word is stored as word 0

`timescale 1ns/100ps

module hdr_word_counter (
  input  logic                            clk,
  input  logic                            reset_i,
  input  logic                            clear_i,
  input  logic                            inc_i,
  output logic [ipv4_csum_pkg::IDX_W-1:0] idx_o,
  output logic                            last_o
);

  logic [ipv4_csum_pkg::IDX_W-1:0] idx_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      idx_q <= '0;
    end else if (clear_i) begin
      // The word that comes with the clear is word 0
      idx_q <= inc_i ? ipv4_csum_pkg::IDX_W'(1) : '0;
    end else if (inc_i) begin
      idx_q <= last_o ? '0 : idx_q + 1'b1;
    end
  end

  assign idx_o  = clear_i ? '0 : idx_q;
  assign last_o = (idx_q == ipv4_csum_pkg::IDX_W'(ipv4_csum_pkg::HDR_WORDS - 1));

  a_idx_range: assert property (@(posedge clk) disable iff (reset_i)
    idx_q <= ipv4_csum_pkg::IDX_W'(ipv4_csum_pkg::HDR_WORDS - 1));

endmodule

// ==== verilog/hdr_collect_fsm.sv ====
// Header collection control, a sop in mid header aborts it with one error pulse
// Words without sop while idle are dropped

`timescale 1ns/100ps

module hdr_collect_fsm (
  input  logic clk,
  input  logic reset_i,
  input  logic hdr_valid_i,
  input  logic hdr_sop_i,
  input  logic last_i,
  output logic cnt_clear_o,
  output logic cnt_inc_o,
  output logic wr_o,
  output logic start_o,
  output logic error_o
);

  typedef enum logic {
    IDLE,
    COLLECT
  } state_t;

  state_t state_q;
  state_t state_d;
  logic   accept;
  logic   abort;
  logic   done;

  // A word is taken while collecting, or when it opens a new header
  assign accept = hdr_valid_i & ((state_q == COLLECT) | hdr_sop_i);
  assign abort  = hdr_valid_i & hdr_sop_i & (state_q == COLLECT);
  // Sop wins over last, so a sop at word 9 still aborts
  assign done   = hdr_valid_i & ~hdr_sop_i & (state_q == COLLECT) & last_i;

  assign wr_o        = accept;
  assign cnt_inc_o   = accept;
  assign cnt_clear_o = hdr_valid_i & hdr_sop_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (hdr_valid_i && hdr_sop_i) begin
          state_d = COLLECT;
        end
      end
      COLLECT: begin
        if (done) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= IDLE;
      start_o <= 1'b0;
      error_o <= 1'b0;
    end else begin
      state_q <= state_d;
      start_o <= done;
      error_o <= abort;
    end
  end

  a_start_single: assert property (@(posedge clk) disable iff (reset_i)
    start_o |=> !start_o);
  a_error_single: assert property (@(posedge clk) disable iff (reset_i)
    error_o |=> !error_o);

endmodule

// ==== verilog/hdr_word_buffer.sv ====
// Header word store, the checksum field goes to its own slot
// Contents hold until overwritten; a new header may reuse them word by word

`timescale 1ns/100ps

module hdr_word_buffer (
  input  logic                             clk,
  input  logic                             reset_i,
  input  logic                             wr_i,
  input  logic [ipv4_csum_pkg::IDX_W-1:0]  idx_i,
  input  logic [ipv4_csum_pkg::WORD_W-1:0] word_i,
  output ipv4_csum_pkg::hdr_words_t        hdr_o
);

  ipv4_csum_pkg::hdr_words_t hdr_q;

  always_ff @(posedge clk) begin
    if (wr_i) begin
      if (idx_i == ipv4_csum_pkg::IDX_W'(ipv4_csum_pkg::CSUM_IDX)) begin
        hdr_q.rx_csum <= word_i;
      end else if (idx_i < ipv4_csum_pkg::IDX_W'(ipv4_csum_pkg::CSUM_IDX)) begin
        hdr_q.sum_words[idx_i] <= word_i;
      end else begin
        // Close the gap left by the checksum field
        hdr_q.sum_words[idx_i - 1'b1] <= word_i;
      end
    end
  end

  assign hdr_o = hdr_q;

  a_wr_idx: assert property (@(posedge clk) disable iff (reset_i)
    wr_i |-> idx_i < ipv4_csum_pkg::IDX_W'(ipv4_csum_pkg::HDR_WORDS));

endmodule

// ==== verilog/csum_adder_tree.sv ====
// Five-stage one's-complement sum of nine words, fold, invert and compare
// Accepts a new start every cycle; no stall, results must be taken when valid

`timescale 1ns/100ps

module csum_adder_tree (
  input  logic                        clk,
  input  logic                        reset_i,
  input  logic                        start_i,
  input  ipv4_csum_pkg::hdr_words_t   hdr_i,
  output logic                        valid_o,
  output ipv4_csum_pkg::csum_result_t result_o
);

  // Sums grow one bit per level so no carry is dropped
  logic [3:0][ipv4_csum_pkg::WORD_W:0]   s1_sum;
  logic [1:0][ipv4_csum_pkg::WORD_W+1:0] s2_sum;
  logic [ipv4_csum_pkg::WORD_W+2:0]      s3_sum;
  logic [ipv4_csum_pkg::WORD_W+3:0]      s4_sum;

  // Ninth word and received field ride alongside
  logic [ipv4_csum_pkg::WORD_W-1:0] s1_w8, s2_w8, s3_w8;
  logic [ipv4_csum_pkg::WORD_W-1:0] s1_rx, s2_rx, s3_rx, s4_rx;

  logic [ipv4_csum_pkg::TREE_LAT-1:0] vld_q;
  ipv4_csum_pkg::csum_result_t        result_q;

  logic [ipv4_csum_pkg::WORD_W:0]   fold1;
  logic [ipv4_csum_pkg::WORD_W-1:0] fold2;
  logic [ipv4_csum_pkg::WORD_W-1:0] csum_d;

  always_ff @(posedge clk) begin
    // Stage 1, pair sums straight from the buffer
    for (int i = 0; i < 4; i++) begin
      s1_sum[i] <= {1'b0, hdr_i.sum_words[2*i]} + {1'b0, hdr_i.sum_words[2*i+1]};
    end
    s1_w8 <= hdr_i.sum_words[8];
    s1_rx <= hdr_i.rx_csum;

    // Stage 2
    s2_sum[0] <= {1'b0, s1_sum[0]} + {1'b0, s1_sum[1]};
    s2_sum[1] <= {1'b0, s1_sum[2]} + {1'b0, s1_sum[3]};
    s2_w8     <= s1_w8;
    s2_rx     <= s1_rx;

    // Stage 3
    s3_sum <= {1'b0, s2_sum[0]} + {1'b0, s2_sum[1]};
    s3_w8  <= s2_w8;
    s3_rx  <= s2_rx;

    // Stage 4 brings in the ninth word
    s4_sum <= {1'b0, s3_sum} + {4'b0, s3_w8};
    s4_rx  <= s3_rx;

    // Stage 5
    result_q.csum  <= csum_d;
    result_q.match <= (csum_d == s4_rx);
  end

  // End-around carry, the upper four bits fold in and at most one carry is left
  assign fold1  = {1'b0, s4_sum[ipv4_csum_pkg::WORD_W-1:0]}
                + {13'b0, s4_sum[ipv4_csum_pkg::WORD_W+3:ipv4_csum_pkg::WORD_W]};
  assign fold2  = fold1[ipv4_csum_pkg::WORD_W-1:0] + fold1[ipv4_csum_pkg::WORD_W];
  assign csum_d = ~fold2;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[ipv4_csum_pkg::TREE_LAT-2:0], start_i};
    end
  end

  assign valid_o  = vld_q[ipv4_csum_pkg::TREE_LAT-1];
  assign result_o = result_q;

  // Stage registers hold the previous cycle's sums while a header is in them
  a_stage1: assert property (@(posedge clk) disable iff (reset_i)
    vld_q[0] |-> s1_sum[0] == $past({1'b0, hdr_i.sum_words[0]} + {1'b0, hdr_i.sum_words[1]})
              && s1_sum[3] == $past({1'b0, hdr_i.sum_words[6]} + {1'b0, hdr_i.sum_words[7]}));
  a_stage2: assert property (@(posedge clk) disable iff (reset_i)
    vld_q[1] |-> s2_sum[0] == $past({1'b0, s1_sum[0]} + {1'b0, s1_sum[1]})
              && s2_sum[1] == $past({1'b0, s1_sum[2]} + {1'b0, s1_sum[3]}));
  a_stage3: assert property (@(posedge clk) disable iff (reset_i)
    vld_q[2] |-> s3_sum == $past({1'b0, s2_sum[0]} + {1'b0, s2_sum[1]}));
  a_stage4: assert property (@(posedge clk) disable iff (reset_i)
    vld_q[3] |-> s4_sum == $past({1'b0, s3_sum} + {4'b0, s3_w8}));

  a_latency: assert property (@(posedge clk) disable iff (reset_i)
    start_i |-> ##(ipv4_csum_pkg::TREE_LAT) valid_o);
  a_no_early: assert property (@(posedge clk) disable iff (reset_i)
    valid_o |-> $past(start_i, ipv4_csum_pkg::TREE_LAT));
  a_known: assert property (@(posedge clk) disable iff (reset_i)
    valid_o |-> !$isunknown(result_o));

endmodule

// ==== verilog/ipv4_csum_top.sv ====
// IPv4 header checksum, 20-byte headers one word per strobe, no back-pressure
// Result appears 6 cycles after the tenth word; headers must be at least ten cycles apart

`timescale 1ns/100ps

module ipv4_csum_top (
  input  logic                             clk,
  input  logic                             reset_i,
  input  logic                             hdr_valid_i,
  input  logic                             hdr_sop_i,
  input  logic [ipv4_csum_pkg::WORD_W-1:0] hdr_word_i,
  output logic                             csum_valid_o,
  output logic [ipv4_csum_pkg::WORD_W-1:0] csum_o,
  output logic                             csum_match_o,
  output logic                             hdr_error_o
);

  logic                            cnt_clear;
  logic                            cnt_inc;
  logic                            cnt_last;
  logic [ipv4_csum_pkg::IDX_W-1:0] word_idx;
  logic                            buf_wr;
  logic                            tree_start;
  ipv4_csum_pkg::hdr_words_t       hdr_words;
  ipv4_csum_pkg::csum_result_t     result;

  hdr_collect_fsm u_fsm (
    .clk         (clk),
    .reset_i     (reset_i),
    .hdr_valid_i (hdr_valid_i),
    .hdr_sop_i   (hdr_sop_i),
    .last_i      (cnt_last),
    .cnt_clear_o (cnt_clear),
    .cnt_inc_o   (cnt_inc),
    .wr_o        (buf_wr),
    .start_o     (tree_start),
    .error_o     (hdr_error_o)
  );

  hdr_word_counter u_counter (
    .clk     (clk),
    .reset_i (reset_i),
    .clear_i (cnt_clear),
    .inc_i   (cnt_inc),
    .idx_o   (word_idx),
    .last_o  (cnt_last)
  );

  hdr_word_buffer u_buffer (
    .clk     (clk),
    .reset_i (reset_i),
    .wr_i    (buf_wr),
    .idx_i   (word_idx),
    .word_i  (hdr_word_i),
    .hdr_o   (hdr_words)
  );

  csum_adder_tree u_tree (
    .clk      (clk),
    .reset_i  (reset_i),
    .start_i  (tree_start),
    .hdr_i    (hdr_words),
    .valid_o  (csum_valid_o),
    .result_o (result)
  );

  assign csum_o       = result.csum;
  assign csum_match_o = result.match;

endmodule

// ==== tb/tb_ipv4_csum.sv ====
// Sends 20-byte headers only and keeps them at least ten cycles apart
// Expected results follow the one's-complement fold rule and not the DUT's adder tree

`timescale 1ns/100ps

module tb_ipv4_csum;

  localparam int CLK_NS      = 4;
  localparam int NUM_HEADERS = 25;
  // Twenty cycles per header plus reset and a margin
  localparam int WATCHDOG_NS = (NUM_HEADERS * 20 + 8 + 200) * CLK_NS;

  typedef logic [ipv4_csum_pkg::HDR_WORDS-1:0][ipv4_csum_pkg::WORD_W-1:0] hdr_t;

  logic                             clk = 1'b0;
  logic                             reset_i;
  logic                             hdr_valid_i;
  logic                             hdr_sop_i;
  logic [ipv4_csum_pkg::WORD_W-1:0] hdr_word_i;
  logic                             csum_valid_o;
  logic [ipv4_csum_pkg::WORD_W-1:0] csum_o;
  logic                             csum_match_o;
  logic                             hdr_error_o;

  // Marks driven alongside the stimulus for the timing checks
  logic last_word  = 1'b0;
  logic abort_word = 1'b0;

  ipv4_csum_pkg::csum_result_t exp_q[$];
  ipv4_csum_pkg::csum_result_t exp_head;
  logic   has_head      = 1'b0;
  integer seed          = 32'hba1c_ee89;
  int     headers_sent  = 0;
  int     results_seen  = 0;
  int     errors        = 0;
  int     errors_at_start;
  int     test_num      = 0;
  int     tests_passed  = 0;
  int     tests_failed  = 0;

  ipv4_csum_top UUT (
    .clk          (clk),
    .reset_i      (reset_i),
    .hdr_valid_i  (hdr_valid_i),
    .hdr_sop_i    (hdr_sop_i),
    .hdr_word_i   (hdr_word_i),
    .csum_valid_o (csum_valid_o),
    .csum_o       (csum_o),
    .csum_match_o (csum_match_o),
    .hdr_error_o  (hdr_error_o)
  );

  always #(CLK_NS / 2) clk = ~clk;

  // Nine words are summed wide and the carries folded back before the inversion
  function automatic ipv4_csum_pkg::csum_result_t expected_result(input hdr_t words);
    logic [19:0]                 sum;
    ipv4_csum_pkg::csum_result_t res;
    sum = '0;
    for (int i = 0; i < ipv4_csum_pkg::HDR_WORDS; i++) begin
      if (i != ipv4_csum_pkg::CSUM_IDX) begin
        sum = sum + {4'b0, words[i]};
      end
    end
    while (sum[19:16] != 4'b0) begin
      sum = {4'b0, sum[15:0]} + {16'b0, sum[19:16]};
    end
    res.csum  = ~sum[15:0];
    res.match = (words[ipv4_csum_pkg::CSUM_IDX] == res.csum);
    return res;
  endfunction

  function automatic hdr_t random_header();
    hdr_t w;
    for (int i = 0; i < ipv4_csum_pkg::HDR_WORDS; i++) begin
      w[i] = ipv4_csum_pkg::WORD_W'($random(seed));
    end
    return w;
  endfunction

  task automatic drive_idle(input int n);
    repeat (n) begin
      @(posedge clk);
      hdr_valid_i <= 1'b0;
      hdr_sop_i   <= 1'b0;
      last_word   <= 1'b0;
      abort_word  <= 1'b0;
    end
  endtask

  task automatic send_stray(input logic [ipv4_csum_pkg::WORD_W-1:0] word);
    @(posedge clk);
    hdr_valid_i <= 1'b1;
    hdr_sop_i   <= 1'b0;
    hdr_word_i  <= word;
    last_word   <= 1'b0;
    abort_word  <= 1'b0;
  endtask

  // Sends words 0 to count-1 only so the header never completes
  task automatic send_partial(input hdr_t words, input int count);
    for (int i = 0; i < count; i++) begin
      @(posedge clk);
      hdr_valid_i <= 1'b1;
      hdr_sop_i   <= (i == 0);
      hdr_word_i  <= words[i];
      last_word   <= 1'b0;
      abort_word  <= 1'b0;
    end
  endtask

  task automatic send_header(input hdr_t words, input bit gaps, input bit aborts);
    int n;
    for (int i = 0; i < ipv4_csum_pkg::HDR_WORDS; i++) begin
      if (gaps && i > 0) begin
        n = $unsigned($random(seed)) % 3;
        drive_idle(n);
      end
      @(posedge clk);
      hdr_valid_i <= 1'b1;
      hdr_sop_i   <= (i == 0);
      hdr_word_i  <= words[i];
      last_word   <= (i == ipv4_csum_pkg::HDR_WORDS - 1);
      abort_word  <= aborts && (i == 0);
    end
    exp_q.push_back(expected_result(words));
    headers_sent++;
  endtask

  task automatic wait_results();
    drive_idle(1);
    while (results_seen < headers_sent) begin
      @(posedge clk);
    end
    drive_idle(2);
  endtask

  task automatic begin_test();
    test_num++;
    errors_at_start = errors;
  endtask

  task automatic end_test(input string name);
    if (errors == errors_at_start) begin
      tests_passed++;
      $display("Test %0d (%s): ok", test_num, name);
    end else begin
      tests_failed++;
      $display("Test %0d (%s): %0d failed checks", test_num, name, errors - errors_at_start);
    end
  endtask

  // Queue head is taken mid-cycle while a result is on the outputs
  always @(negedge clk) begin
    if (csum_valid_o && exp_q.size() > 0) begin
      exp_head = exp_q.pop_front();
      has_head = 1'b1;
      results_seen++;
    end else begin
      has_head = 1'b0;
    end
  end

  a_reset: assert property (@(posedge clk) reset_i |=> !csum_valid_o && !hdr_error_o)
    else begin
      errors++;
      $display("Outputs were not low after a reset cycle");
    end
  a_unexpected: assert property (@(posedge clk) disable iff (reset_i)
    csum_valid_o |-> has_head)
    else begin
      errors++;
      $display("A result came out with no header waiting for one");
    end
  a_csum: assert property (@(posedge clk) disable iff (reset_i)
    csum_valid_o && has_head |-> csum_o == exp_head.csum)
    else begin
      errors++;
      $display("Mismatch csum_o: got %h, expected %h", $sampled(csum_o), $sampled(exp_head.csum));
    end
  a_match: assert property (@(posedge clk) disable iff (reset_i)
    csum_valid_o && has_head |-> csum_match_o == exp_head.match)
    else begin
      errors++;
      $display("Mismatch csum_match_o: got %h, expected %h",
               $sampled(csum_match_o), $sampled(exp_head.match));
    end
  a_latency: assert property (@(posedge clk) disable iff (reset_i)
    last_word |-> ##6 csum_valid_o)
    else begin
      errors++;
      $display("No result 6 cycles after the tenth word");
    end
  a_valid_source: assert property (@(posedge clk) disable iff (reset_i)
    csum_valid_o |-> $past(last_word, 6))
    else begin
      errors++;
      $display("Result pulse without a tenth word 6 cycles before");
    end
  a_error_pulse: assert property (@(posedge clk) disable iff (reset_i)
    abort_word |=> hdr_error_o)
    else begin
      errors++;
      $display("Mid-header sop did not raise the error pulse");
    end
  a_error_source: assert property (@(posedge clk) disable iff (reset_i)
    hdr_error_o |-> $past(abort_word))
    else begin
      errors++;
      $display("Error pulse without a mid-header sop");
    end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before all tests finished");
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    hdr_t                        w;
    ipv4_csum_pkg::csum_result_t r;
    reset_i     = 1'b1;
    hdr_valid_i = 1'b0;
    hdr_sop_i   = 1'b0;
    hdr_word_i  = '0;
    repeat (8) @(posedge clk);
    reset_i <= 1'b0;

    begin_test();
    drive_idle(4);
    send_stray(16'h4500);
    drive_idle(12);
    send_header(random_header(), 1'b0, 1'b0);
    wait_results();
    end_test("reset state and stray word");

    begin_test();
    repeat (8) send_header(random_header(), 1'b0, 1'b0);
    wait_results();
    end_test("random headers without gaps");

    begin_test();
    w = random_header();
    r = expected_result(w);
    w[ipv4_csum_pkg::CSUM_IDX] = r.csum;
    send_header(w, 1'b0, 1'b0);
    // Flip one bit so the field no longer agrees
    w[ipv4_csum_pkg::CSUM_IDX] = w[ipv4_csum_pkg::CSUM_IDX] ^ 16'h0100;
    send_header(w, 1'b0, 1'b0);
    wait_results();
    end_test("checksum field match and mismatch");

    begin_test();
    repeat (6) send_header(random_header(), 1'b1, 1'b0);
    wait_results();
    end_test("random gaps within headers");

    begin_test();
    send_partial(random_header(), 4);
    send_header(random_header(), 1'b0, 1'b1);
    wait_results();
    end_test("abort by sop at word 4");

    begin_test();
    send_header({ipv4_csum_pkg::HDR_WORDS{16'hffff}}, 1'b0, 1'b0);
    send_header('0, 1'b0, 1'b0);
    repeat (4) send_header(random_header(), 1'b0, 1'b0);
    wait_results();
    end_test("carry corners and back-to-back order");

    drive_idle(8);
    $display("Tests passed: %0d, tests failed: %0d, failed checks: %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
verilog/ipv4_csum_pkg.sv
verilog/hdr_word_counter.sv
verilog/hdr_collect_fsm.sv
verilog/hdr_word_buffer.sv
verilog/csum_adder_tree.sv
verilog/ipv4_csum_top.sv
tb/tb_ipv4_csum.sv
